// ==== tb/dma_vectors.txt ====
# columns: op pe addr be data expect, numbers in hex, addr is a byte offset or a word address
# RW RR register access, EW ER external word, FL fill, CK check region, LB launch both, PL poll
RW 0 00 f 00000040 0
RR 0 00 0 0 00000040
RW 0 08 f 00000200 0
RR 0 08 0 0 00000200
RW 0 10 f 11223344 0
RW 0 10 5 aabbccdd 0
RR 0 10 0 0 11bb33dd
RW 0 10 a 55667788 0
RR 0 10 0 0 55bb77dd
RW 0 10 0 ffffffff 0
RR 0 10 0 0 55bb77dd
RW 0 30 f deadbeef 0
RR 0 30 0 0 00000000
RR 1 04 0 0 00000000
RR 1 20 0 0 00000000
RR 1 18 0 0 00000000
EW 0 f0 0 cafef00d 0
ER 0 f0 0 0 cafef00d
FL 0 10 0 10 0
RW 0 10 f 00000040 0
RR 0 20 0 0 00000001
RR 0 18 0 0 00010000
CK 0 10 0 10 0
PL 0 00 0 0 00000001
CK 0 80 0 10 0
RR 0 18 0 0 00000000
RR 0 28 0 0 00000001
FL 0 40 0 8 0
FL 0 60 0 8 0
RW 0 00 f 00000100 0
RW 0 08 f 00000300 0
RW 0 10 f 00000020 0
RW 1 00 f 00000180 0
RW 1 08 f 00000380 0
RW 1 10 f 00000020 0
LB 0 00 0 0 00000002
PL 0 00 0 0 00000003
CK 0 c0 0 8 0
CK 0 e0 0 8 0
RR 1 28 0 0 00000003
RR 0 18 0 0 00000000
RR 1 18 0 0 00000000

// ==== project.f ====
source/dma_reg_pkg.sv
source/dma_xfer_pkg.sv
source/dma_frontend_regs.sv
source/dma_rr_arbiter.sv
source/dma_id_tracker.sv
source/dma_copy_engine.sv
source/dma_scratch_mem.sv
source/dma_cluster_top.sv
tb/tb_dma_cluster.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dma_cluster
RTL_TOP   ?= dma_cluster_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_dma_cluster.sv ====
// vector-driven testbench for the cluster DMA, run from the project root with tb/dma_vectors.txt
`timescale 1ns/100ps

module tb_dma_cluster
    import dma_reg_pkg::*;
    import dma_xfer_pkg::*;
();

    localparam int unsigned MaxVectors  = 64;
    localparam int unsigned CyclesPerOp = 64;
    localparam logic [31:0] RngSeed     = 32'd92440;

    logic                   clk;
    logic                   rst_n;
    ctrl_req_t [NumPes-1:0] ctrl_req;
    ctrl_rsp_t [NumPes-1:0] ctrl_rsp;
    logic                   ext_req;
    mem_req_t               ext_payload;
    logic                   ext_gnt;
    logic                   ext_rvalid;
    logic [31:0]            ext_rdata;

    // one entry per operation line of the vector file
    logic [15:0] vec_op   [MaxVectors];
    logic [31:0] vec_pe   [MaxVectors];
    logic [31:0] vec_addr [MaxVectors];
    logic [31:0] vec_be   [MaxVectors];
    logic [31:0] vec_data [MaxVectors];
    logic [31:0] vec_exp  [MaxVectors];
    int unsigned num_vectors;

    // reference model of the scratch memory and of each PE's descriptor
    logic [31:0] ref_mem    [MemWords];
    logic [31:0] shadow_src [NumPes];
    logic [31:0] shadow_dst [NumPes];
    logic [31:0] shadow_len [NumPes];
    logic [31:0] rng_state;

    int unsigned checks;
    int unsigned errors;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit;

    dma_cluster_top u_dut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .ctrl_req_i   (ctrl_req),
        .ctrl_rsp_o   (ctrl_rsp),
        .ext_req_i    (ext_req),
        .ext_payload_i(ext_payload),
        .ext_gnt_o    (ext_gnt),
        .ext_rvalid_o (ext_rvalid),
        .ext_rdata_o  (ext_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, the DUT stopped answering", cycle_count));
        end
    end

    // inputs change a short delay after the rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  be);
        logic [31:0] res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = be[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // request is held until granted, response is sampled mid-cycle one cycle later
    task automatic ctrl_access(input int pe, input logic rd, input logic [3:0] be,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        logic granted;
        step();
        ctrl_req[pe].req   = 1'b1;
        ctrl_req[pe].rd    = rd;
        ctrl_req[pe].be    = be;
        ctrl_req[pe].addr  = addr;
        ctrl_req[pe].wdata = wdata;
        granted = 1'b0;
        while (!granted) begin
            #40;
            granted = ctrl_rsp[pe].gnt;
            step();
        end
        ctrl_req[pe] = '0;
        #40;
        check_value($sformatf("ctrl_rsp_o[%0d].valid", pe), 32'(ctrl_rsp[pe].valid), 32'd1);
        rdata = ctrl_rsp[pe].rdata;
    endtask

    task automatic ext_access(input logic we, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        logic granted;
        rdata = '0;
        step();
        ext_req           = 1'b1;
        ext_payload.we    = we;
        ext_payload.addr  = addr;
        ext_payload.wdata = wdata;
        granted = 1'b0;
        while (!granted) begin
            #40;
            granted = ext_gnt;
            step();
        end
        ext_req     = 1'b0;
        ext_payload = '0;
        if (!we) begin
            #40;
            check_value("ext_rvalid_o", 32'(ext_rvalid), 32'd1);
            rdata = ext_rdata;
        end
    endtask

    // word copy in the reference memory, addresses wrap at the memory size
    task automatic apply_copy(input int pe);
        logic [7:0]  src;
        logic [7:0]  dst;
        logic [31:0] words;
        src   = shadow_src[pe][9:2];
        dst   = shadow_dst[pe][9:2];
        words = shadow_len[pe] >> 2;
        for (int unsigned i = 0; i < words; i++) begin
            ref_mem[dst + 8'(i)] = ref_mem[src + 8'(i)];
        end
    endtask

    task automatic fill_region(input logic [7:0] base, input logic [31:0] count);
        logic [7:0]  addr;
        logic [31:0] rdata;
        for (int unsigned i = 0; i < count; i++) begin
            addr      = base + 8'(i);
            rng_state = xorshift32(rng_state);
            ext_access(1'b1, addr, rng_state, rdata);
            ref_mem[addr] = rng_state;
        end
    endtask

    task automatic check_region(input logic [7:0] base, input logic [31:0] count);
        logic [7:0]  addr;
        logic [31:0] rdata;
        for (int unsigned i = 0; i < count; i++) begin
            addr = base + 8'(i);
            ext_access(1'b0, addr, '0, rdata);
            check_value($sformatf("ext_rdata_o at word %02h", addr), rdata, ref_mem[addr]);
        end
    endtask

    task automatic poll_done(input int pe, input logic [31:0] exp);
        logic [31:0] rdata;
        rdata = '0;
        while (rdata < exp) begin
            ctrl_access(pe, 1'b1, 4'h0, {24'h0, RegDoneId}, '0, rdata);
        end
        check_value($sformatf("ctrl_rsp_o[%0d].rdata done ID", pe), rdata, exp);
    endtask

    // both PEs read the next ID together, the arbiter serializes them
    task automatic launch_both(input logic [31:0] first_id);
        logic [31:0] id0;
        logic [31:0] id1;
        fork
            ctrl_access(0, 1'b1, 4'h0, {24'h0, RegNextId}, '0, id0);
            ctrl_access(1, 1'b1, 4'h0, {24'h0, RegNextId}, '0, id1);
        join
        if (id0 < id1) begin
            check_value("lower launch ID", id0, first_id);
            check_value("higher launch ID", id1, first_id + 1);
            apply_copy(0);
            apply_copy(1);
        end else begin
            check_value("lower launch ID", id1, first_id);
            check_value("higher launch ID", id0, first_id + 1);
            apply_copy(1);
            apply_copy(0);
        end
    endtask

    task automatic run_vector(input int unsigned idx);
        int          pe;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] rdata;
        int unsigned errors_before;

        pe            = int'(vec_pe[idx]);
        addr          = vec_addr[idx];
        be            = vec_be[idx][3:0];
        errors_before = errors;
        case (vec_op[idx])
            "RW": begin
                ctrl_access(pe, 1'b0, be, addr, vec_data[idx], rdata);
                case (addr[7:0])
                    RegSrcAddr:  shadow_src[pe] = merge_bytes(shadow_src[pe], vec_data[idx], be);
                    RegDstAddr:  shadow_dst[pe] = merge_bytes(shadow_dst[pe], vec_data[idx], be);
                    RegNumBytes: shadow_len[pe] = merge_bytes(shadow_len[pe], vec_data[idx], be);
                    default:     ;
                endcase
            end
            "RR": begin
                ctrl_access(pe, 1'b1, be, addr, '0, rdata);
                check_value($sformatf("ctrl_rsp_o[%0d].rdata at offset %02h", pe, addr[7:0]),
                            rdata, vec_exp[idx]);
                // next-ID read with a nonzero length starts a copy
                if (addr[7:0] == RegNextId && shadow_len[pe] != '0) begin
                    apply_copy(pe);
                end
            end
            "EW": begin
                ext_access(1'b1, addr[7:0], vec_data[idx], rdata);
                ref_mem[addr[7:0]] = vec_data[idx];
            end
            "ER": begin
                ext_access(1'b0, addr[7:0], '0, rdata);
                check_value("ext_rdata_o", rdata, vec_exp[idx]);
            end
            "FL": fill_region(addr[7:0], vec_data[idx]);
            "CK": check_region(addr[7:0], vec_data[idx]);
            "LB": launch_both(vec_exp[idx]);
            "PL": poll_done(pe, vec_exp[idx]);
            default: begin
                errors++;
                $display("unknown operation code in vector %0d", idx + 1);
            end
        endcase
        $display("test %0d %s %s", idx + 1, vec_op[idx],
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    task automatic read_vectors();
        int               fd;
        int               n;
        logic [15:0]      op;
        logic [31:0]      f_pe;
        logic [31:0]      f_addr;
        logic [31:0]      f_be;
        logic [31:0]      f_data;
        logic [31:0]      f_exp;
        logic [8*160-1:0] rest;

        num_vectors = 0;
        fd = $fopen("tb/dma_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the vector file tb/dma_vectors.txt");
        end else begin
            while (!$feof(fd) && num_vectors < MaxVectors) begin
                op = '0;
                n  = $fscanf(fd, "%s", op);
                if (n != 1) begin
                    break;
                end
                if (op[7:0] == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    n = $fscanf(fd, "%h %h %h %h %h", f_pe, f_addr, f_be, f_data, f_exp);
                    if (n != 5) begin
                        errors++;
                        $display("malformed vector line after %0d operations", num_vectors);
                        break;
                    end
                    vec_op[num_vectors]   = op;
                    vec_pe[num_vectors]   = f_pe;
                    vec_addr[num_vectors] = f_addr;
                    vec_be[num_vectors]   = f_be;
                    vec_data[num_vectors] = f_data;
                    vec_exp[num_vectors]  = f_exp;
                    num_vectors++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : main
        int unsigned errors_at_reset;

        ctrl_req    = '0;
        ext_req     = 1'b0;
        ext_payload = '0;
        rst_n       = 1'b0;
        checks      = 0;
        errors      = 0;
        cycle_limit = 0;
        rng_state   = RngSeed;
        for (int i = 0; i < NumPes; i++) begin
            shadow_src[i] = '0;
            shadow_dst[i] = '0;
            shadow_len[i] = '0;
        end

        read_vectors();
        if (num_vectors == 0) begin
            errors++;
            $display("the vector file holds no operations");
        end
        // budget grows with the number of operations
        cycle_limit = num_vectors * CyclesPerOp;

        repeat (10) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // nothing is requested yet, so every handshake output is idle
        errors_at_reset = errors;
        #40;
        for (int i = 0; i < NumPes; i++) begin
            check_value($sformatf("ctrl_rsp_o[%0d].gnt", i), 32'(ctrl_rsp[i].gnt), 32'd0);
            check_value($sformatf("ctrl_rsp_o[%0d].valid", i), 32'(ctrl_rsp[i].valid), 32'd0);
        end
        check_value("ext_gnt_o", 32'(ext_gnt), 32'd0);
        check_value("ext_rvalid_o", 32'(ext_rvalid), 32'd0);
        $display("reset state %s", (errors == errors_at_reset) ? "ok" : "mismatch");

        for (int unsigned i = 0; i < num_vectors; i++) begin
            run_vector(i);
        end

        $display("tests %0d, checks %0d, errors %0d", num_vectors, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== source/dma_cluster_top.sv ====
// cluster DMA top level, wires PE register files, arbiters, ID tracker, engine and memory
`timescale 1ns/100ps

module dma_cluster_top
    import dma_reg_pkg::*;
    import dma_xfer_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  ctrl_req_t [NumPes-1:0] ctrl_req_i,
    output ctrl_rsp_t [NumPes-1:0] ctrl_rsp_o,
    input  logic                   ext_req_i,
    input  mem_req_t               ext_payload_i,
    output logic                   ext_gnt_o,
    output logic                   ext_rvalid_o,
    output logic [31:0]            ext_rdata_o
);

    logic [NumPes-1:0]       launch_valid;
    logic [NumPes-1:0]       launch_ready;
    xfer_descr_t [NumPes-1:0] pe_descr;
    xfer_descr_t             eng_descr;
    logic                    eng_descr_valid;
    logic                    eng_ready;
    logic                    eng_busy;
    logic                    eng_done;
    logic [IdWidth-1:0]      next_id;
    logic [IdWidth-1:0]      done_id;
    logic                    eng_mem_req;
    mem_req_t                eng_mem_payload;
    logic [NumPes-1:0]       mem_gnt;
    mem_req_t                mem_payload;
    logic                    mem_valid;
    logic                    mem_rvalid;
    logic [31:0]             mem_rdata;

    for (genvar i = 0; i < NumPes; i++) begin : g_pe
        dma_frontend_regs u_regs (
            .clk_i         (clk_i),
            .rst_ni        (rst_ni),
            .ctrl_req_i    (ctrl_req_i[i]),
            .ctrl_rsp_o    (ctrl_rsp_o[i]),
            .next_id_i     (next_id),
            .done_id_i     (done_id),
            .launch_ready_i(launch_ready[i]),
            .launch_valid_o(launch_valid[i]),
            .busy_i        (eng_busy),
            .descr_o       (pe_descr[i])
        );
    end

    // PE launches only pass while the engine is idle
    dma_rr_arbiter #(.payload_t(xfer_descr_t)) u_descr_arb (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (launch_valid),
        .payload_i(pe_descr),
        .gnt_o    (launch_ready),
        .payload_o(eng_descr),
        .valid_o  (eng_descr_valid),
        .ready_i  (eng_ready)
    );

    dma_id_tracker u_id_tracker (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .launch_i (|launch_ready),
        .done_i   (eng_done),
        .next_id_o(next_id),
        .done_id_o(done_id)
    );

    dma_copy_engine u_engine (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .descr_valid_i(eng_descr_valid),
        .descr_i      (eng_descr),
        .ready_o      (eng_ready),
        .busy_o       (eng_busy),
        .done_o       (eng_done),
        .mem_req_o    (eng_mem_req),
        .mem_payload_o(eng_mem_payload),
        .mem_gnt_i    (mem_gnt[0]),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata)
    );

    // requester 0 is the engine, 1 the external port; memory never stalls
    dma_rr_arbiter #(.payload_t(mem_req_t)) u_mem_arb (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    ({ext_req_i, eng_mem_req}),
        .payload_i({ext_payload_i, eng_mem_payload}),
        .gnt_o    (mem_gnt),
        .payload_o(mem_payload),
        .valid_o  (mem_valid),
        .ready_i  (1'b1)
    );

    dma_scratch_mem u_mem (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (mem_valid),
        .req_payload_i(mem_payload),
        .rvalid_o     (mem_rvalid),
        .rdata_o      (mem_rdata)
    );

    // read beats are broadcast, a requester takes the one after its own grant
    assign ext_gnt_o    = mem_gnt[1];
    assign ext_rvalid_o = mem_rvalid;
    assign ext_rdata_o  = mem_rdata;

endmodule

// ==== source/dma_scratch_mem.sv ====
// single-port scratch memory of 32-bit words, read data and valid are registered
`timescale 1ns/100ps

module dma_scratch_mem
    import dma_xfer_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        req_i,
    input  mem_req_t    req_payload_i,
    output logic        rvalid_o,
    output logic [31:0] rdata_o
);

    logic [31:0] mem_q [MemWords];
    logic [31:0] rdata_q;
    logic        rvalid_q;

    always_ff @(posedge clk_i) begin
        if (req_i && req_payload_i.we) begin
            mem_q[req_payload_i.addr] <= req_payload_i.wdata;
        end
        if (req_i && !req_payload_i.we) begin
            rdata_q <= mem_q[req_payload_i.addr];
        end
    end

    // valid only for reads, writes return nothing
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i & ~req_payload_i.we;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

endmodule

// ==== source/dma_copy_engine.sv ====
// copy backend, moves one descriptor's words through the memory arbiter by read then write
`timescale 1ns/100ps

module dma_copy_engine
    import dma_xfer_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        descr_valid_i,
    input  xfer_descr_t descr_i,
    output logic        ready_o,
    output logic        busy_o,
    output logic        done_o,
    output logic        mem_req_o,
    output mem_req_t    mem_payload_o,
    input  logic        mem_gnt_i,
    input  logic        mem_rvalid_i,
    input  logic [31:0] mem_rdata_i
);

    typedef enum logic [1:0] {
        StIdle,
        StRead,
        StWait,
        StWrite
    } state_e;

    state_e                  state_q;
    state_e                  state_d;
    logic [MemAddrWidth-1:0] src_q;
    logic [MemAddrWidth-1:0] src_d;
    logic [MemAddrWidth-1:0] dst_q;
    logic [MemAddrWidth-1:0] dst_d;
    logic [29:0]             words_q;
    logic [29:0]             words_d;
    logic [31:0]             data_q;
    logic                    done_q;
    logic                    done_d;

    always_comb begin
        state_d             = state_q;
        src_d               = src_q;
        dst_d               = dst_q;
        words_d             = words_q;
        done_d              = 1'b0;
        mem_req_o           = 1'b0;
        mem_payload_o.we    = 1'b0;
        mem_payload_o.addr  = src_q;
        mem_payload_o.wdata = data_q;

        case (state_q)
            StIdle: begin
                // byte addresses to word addresses, low two bits dropped
                if (descr_valid_i) begin
                    src_d   = descr_i.src_addr[MemAddrWidth+1:2];
                    dst_d   = descr_i.dst_addr[MemAddrWidth+1:2];
                    words_d = descr_i.num_bytes[31:2];
                    state_d = StRead;
                end
            end
            StRead: begin
                mem_req_o = 1'b1;
                if (mem_gnt_i) begin
                    state_d = StWait;
                end
            end
            StWait: begin
                // fixed one-cycle latency, this beat is our own read
                if (mem_rvalid_i) begin
                    state_d = StWrite;
                end
            end
            StWrite: begin
                mem_req_o          = 1'b1;
                mem_payload_o.we   = 1'b1;
                mem_payload_o.addr = dst_q;
                if (mem_gnt_i) begin
                    src_d   = src_q + 1'b1;
                    dst_d   = dst_q + 1'b1;
                    words_d = words_q - 1'b1;
                    if (words_q <= 30'd1) begin
                        state_d = StIdle;
                        done_d  = 1'b1;
                    end else begin
                        state_d = StRead;
                    end
                end
            end
            default: begin
                state_d = StIdle;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= StIdle;
            src_q   <= '0;
            dst_q   <= '0;
            words_q <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            src_q   <= src_d;
            dst_q   <= dst_d;
            words_q <= words_d;
            done_q  <= done_d;
        end
    end

    // word in flight between read and write
    always_ff @(posedge clk_i) begin
        if (state_q == StWait && mem_rvalid_i) begin
            data_q <= mem_rdata_i;
        end
    end

    assign ready_o = (state_q == StIdle);
    assign busy_o  = (state_q != StIdle);
    // done pulses in the first idle cycle, together with busy falling
    assign done_o  = done_q;

endmodule

// ==== source/dma_id_tracker.sv ====
// hands out transfer IDs on launch and counts completed transfers for the done-ID register
`timescale 1ns/100ps

module dma_id_tracker
    import dma_xfer_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               launch_i,
    input  logic               done_i,
    output logic [IdWidth-1:0] next_id_o,
    output logic [IdWidth-1:0] done_id_o
);

    logic [IdWidth-1:0] next_id_q;
    logic [IdWidth-1:0] done_id_q;
    logic [IdWidth-1:0] last_id;

    // both counters wrap at the ID width
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            next_id_q <= IdWidth'(1);
            done_id_q <= '0;
        end else begin
            if (launch_i) begin
                next_id_q <= next_id_q + 1'b1;
            end
            if (done_i) begin
                done_id_q <= done_id_q + 1'b1;
            end
        end
    end

    assign next_id_o = next_id_q;
    assign done_id_o = done_id_q;
    assign last_id   = next_id_q - 1'b1;

    // a completion needs an issued transfer that is still open
    a_done_not_past_issued: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        done_i |-> (done_id_q != last_id)
    );

endmodule

// ==== source/dma_rr_arbiter.sv ====
// round-robin arbiter with a typed payload, serves both descriptor and memory requests
`timescale 1ns/100ps

module dma_rr_arbiter
    import dma_xfer_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic     [NumPes-1:0] req_i,
    input  payload_t [NumPes-1:0] payload_i,
    output logic     [NumPes-1:0] gnt_o,
    output payload_t              payload_o,
    output logic                  valid_o,
    input  logic                  ready_i
);

    // requester with the highest priority this cycle
    logic [PeIdxWidth-1:0] prio_q;
    logic [PeIdxWidth-1:0] prio_d;

    always_comb begin : pick
        int unsigned idx;
        logic        found;

        gnt_o     = '0;
        payload_o = payload_i[0];
        prio_d    = prio_q;
        found     = 1'b0;
        for (int unsigned i = 0; i < NumPes; i++) begin
            idx = prio_q + i;
            if (idx >= NumPes) begin
                idx = idx - NumPes;
            end
            if (!found && req_i[idx]) begin
                found     = 1'b1;
                payload_o = payload_i[idx];
                if (ready_i) begin
                    gnt_o[idx] = 1'b1;
                    // the one after the winner goes first next time
                    prio_d = (idx == NumPes - 1) ? '0 : PeIdxWidth'(idx + 1);
                end
            end
        end
    end

    assign valid_o = |req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= '0;
        end else begin
            prio_q <= prio_d;
        end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_o));

endmodule

// ==== source/dma_frontend_regs.sv ====
// per-PE register file, decodes control accesses and hands descriptors to the copy engine
`timescale 1ns/100ps

module dma_frontend_regs
    import dma_reg_pkg::*;
    import dma_xfer_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  ctrl_req_t          ctrl_req_i,
    output ctrl_rsp_t          ctrl_rsp_o,
    input  logic [IdWidth-1:0] next_id_i,
    input  logic [IdWidth-1:0] done_id_i,
    input  logic               launch_ready_i,
    output logic               launch_valid_o,
    input  logic               busy_i,
    output xfer_descr_t        descr_o
);

    logic [7:0]  reg_addr;
    logic        is_write;
    logic        is_read;
    logic [31:0] cur_val;
    logic [31:0] wr_val;
    logic        gnt;
    logic [31:0] rdata_d;
    logic [31:0] rdata_q;
    logic        valid_q;
    xfer_descr_t descr_d;
    xfer_descr_t descr_q;

    // only the low byte selects a register
    assign reg_addr = ctrl_req_i.addr[7:0];
    assign is_write = ctrl_req_i.req & ~ctrl_req_i.rd;
    assign is_read  = ctrl_req_i.req & ctrl_req_i.rd;

    // old contents of the addressed descriptor register
    always_comb begin
        case (reg_addr)
            RegSrcAddr:  cur_val = descr_q.src_addr;
            RegDstAddr:  cur_val = descr_q.dst_addr;
            RegNumBytes: cur_val = descr_q.num_bytes;
            default:     cur_val = '0;
        endcase
    end

    // per-byte merge, disabled lanes keep the old value
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wr_val[8*i +: 8] = ctrl_req_i.be[i] ? ctrl_req_i.wdata[8*i +: 8] : cur_val[8*i +: 8];
        end
    end

    always_comb begin
        gnt            = 1'b0;
        rdata_d        = '0;
        launch_valid_o = 1'b0;
        descr_d        = descr_q;

        if (ctrl_req_i.req) begin
            gnt = 1'b1;
            case (reg_addr)
                RegSrcAddr: begin
                    rdata_d = descr_q.src_addr;
                    if (is_write) begin
                        descr_d.src_addr = wr_val;
                    end
                end
                RegDstAddr: begin
                    rdata_d = descr_q.dst_addr;
                    if (is_write) begin
                        descr_d.dst_addr = wr_val;
                    end
                end
                RegNumBytes: begin
                    rdata_d = descr_q.num_bytes;
                    if (is_write) begin
                        descr_d.num_bytes = wr_val;
                    end
                end
                RegStatus: begin
                    rdata_d[StatusBusyBit] = busy_i;
                end
                RegNextId: begin
                    // empty descriptor answers 0 right away and launches nothing
                    if (is_read && descr_q.num_bytes != '0) begin
                        launch_valid_o = 1'b1;
                        gnt            = launch_ready_i;
                        rdata_d        = {{(32-IdWidth){1'b0}}, next_id_i};
                    end
                end
                RegDoneId: begin
                    rdata_d = {{(32-IdWidth){1'b0}}, done_id_i};
                end
                default: begin
                    rdata_d = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            descr_q <= '0;
            valid_q <= 1'b0;
        end else begin
            descr_q <= descr_d;
            valid_q <= ctrl_req_i.req & gnt;
        end
    end

    // read data lags the grant by one cycle
    always_ff @(posedge clk_i) begin
        rdata_q <= rdata_d;
    end

    assign ctrl_rsp_o.gnt   = gnt;
    assign ctrl_rsp_o.valid = valid_q;
    assign ctrl_rsp_o.rdata = rdata_q;
    assign descr_o          = descr_q;

    // a stalled request stays on the bus unchanged until it is granted
    a_req_held_until_gnt: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ctrl_req_i.req && !ctrl_rsp_o.gnt |=>
            ctrl_req_i.req && $stable(ctrl_req_i.addr) && $stable(ctrl_req_i.rd)
    );

endmodule

// ==== source/dma_xfer_pkg.sv ====
// transfer and memory definitions used by the copy datapath, tracker and scratch memory
package dma_xfer_pkg;

    // number of PEs with their own register file
    localparam int unsigned NumPes     = 2;
    localparam int unsigned PeIdxWidth = $clog2(NumPes);

    // transfer ID width, upper bits of the 32-bit register read as zero
    localparam int unsigned IdWidth = 28;

    // scratch memory geometry in 32-bit words
    localparam int unsigned MemWords     = 256;
    localparam int unsigned MemAddrWidth = 8;

    // one copy job, addresses are byte addresses
    typedef struct packed {
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
        logic [31:0] num_bytes;
    } xfer_descr_t;

    // word request towards the scratch memory
    typedef struct packed {
        logic                    we;
        logic [MemAddrWidth-1:0] addr;
        logic [31:0]             wdata;
    } mem_req_t;

endpackage

// ==== source/dma_reg_pkg.sv ====
// control bus definitions shared by the per-PE register files and the cluster top level
package dma_reg_pkg;

    // byte offsets inside one PE's register window
    localparam logic [7:0] RegSrcAddr  = 8'h00;
    localparam logic [7:0] RegDstAddr  = 8'h08;
    localparam logic [7:0] RegNumBytes = 8'h10;
    localparam logic [7:0] RegStatus   = 8'h18;
    localparam logic [7:0] RegNextId   = 8'h20;
    localparam logic [7:0] RegDoneId   = 8'h28;

    // busy flag position in the status register
    localparam int unsigned StatusBusyBit = 16;

    // request from a PE, rd high means read
    typedef struct packed {
        logic        req;
        logic        rd;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } ctrl_req_t;

    // gnt is same cycle, valid and rdata come one cycle later
    typedef struct packed {
        logic        gnt;
        logic        valid;
        logic [31:0] rdata;
    } ctrl_rsp_t;

endpackage
